// ==== src/panelPkg.sv ====
// shared definitions for the CPU debug panel
// switch indices, address map bounds, LCD command bytes, character type
package panelPkg;

    // debounced inputs, one bit each in the switch vector
    localparam int SWITCH_COUNT = 5;
    localparam int SW_HALT = 0;
    localparam int SW_IRQ = 1;
    localparam int SW_NMI = 2;
    localparam int SW_RES = 3;
    localparam int SW_CLEAR = 4;

    // level after reset, control lines idle high, clear button idle low
    localparam logic [SWITCH_COUNT-1:0] SWITCH_RESET_LEVEL = 5'b01111;

    // upper bound of each region, inclusive
    localparam logic [15:0] RAM_END = 16'h3FFF;
    localparam logic [15:0] CART_LO_END = 16'h7FFF;
    localparam logic [15:0] CART_HI_END = 16'hBFFF;
    // bios runs from here to the top of the map
    localparam logic [15:0] BIOS_BASE = 16'hF800;

    // floating bus reads as all ones
    localparam logic [7:0] OPEN_BUS = 8'hFF;

    // one character or command byte for the LCD
    typedef logic [7:0] lcdChar;

    // HD44780 style commands
    localparam lcdChar LCD_CLEAR = 8'h01;
    // DDRAM address 0x40, first column of line 2
    localparam lcdChar LCD_LINE2 = 8'hC0;
    // cursor increments, no display shift
    localparam lcdChar LCD_ENTRY = 8'h06;
    // display on, cursor and blink off
    localparam lcdChar LCD_DISPLAY_ON = 8'h0C;
    // 4-bit bus, two lines, 5x8 font
    localparam lcdChar LCD_FUNCTION_4BIT = 8'h28;

endpackage

// ==== src/switchSampler.sv ====
// two-flop synchronizer for the board switches
// plus the shared sample strobe for the debouncers
`timescale 1ns/1ps

module switchSampler #(
    parameter int SAMPLE_DIV = 50000
) (
    input  logic clk,
    input  logic rstN,
    input  logic [panelPkg::SWITCH_COUNT-1:0] rawSwitch,
    output logic [panelPkg::SWITCH_COUNT-1:0] syncSwitch,
    output logic sampleTick
);
    import panelPkg::*;

    localparam int DIV_W = $clog2(SAMPLE_DIV + 1);

    logic [SWITCH_COUNT-1:0] metaSwitch;
    logic [DIV_W-1:0] divCount;

    // switches are asynchronous to clk
    always_ff @(posedge clk) begin
        metaSwitch <= rawSwitch;
        syncSwitch <= metaSwitch;
    end

    // count down, strobe on zero and reload
    // first strobe lands SAMPLE_DIV cycles out of reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            divCount <= DIV_W'(SAMPLE_DIV - 1);
            sampleTick <= 1'b0;
        end else begin
            sampleTick <= (divCount == '0);
            if (divCount == '0)
                divCount <= DIV_W'(SAMPLE_DIV - 1);
            else
                divCount <= divCount - 1'b1;
        end
    end

endmodule

// ==== src/debounce.sv ====
// single switch debouncer
// output follows the input after DEBOUNCE_SAMPLES differing sample ticks
`timescale 1ns/1ps

module debounce #(
    parameter int DEBOUNCE_SAMPLES = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic sampleTick,
    input  logic rawLevel,
    input  logic resetLevel,
    output logic stableLevel
);

    localparam int CNT_W = $clog2(DEBOUNCE_SAMPLES + 1);

    // ticks in a row on which input and output disagree
    logic [CNT_W-1:0] diffCount;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stableLevel <= resetLevel;
            diffCount <= '0;
        end else if (sampleTick) begin
            if (rawLevel == stableLevel) begin
                // any agreement starts the count over
                diffCount <= '0;
            end else if (diffCount == CNT_W'(DEBOUNCE_SAMPLES - 1)) begin
                stableLevel <= rawLevel;
                diffCount <= '0;
            end else begin
                diffCount <= diffCount + 1'b1;
            end
        end
    end

    // level only moves right after a strobe from the sampler
    changeOnTick: assert property (@(posedge clk) disable iff (!rstN)
        $changed(stableLevel) |-> $past(sampleTick));

endmodule

// ==== src/addressDecoder.sv ====
// CPU address map decode
// chip selects for RAM, both cartridge banks and BIOS, read data mux
`timescale 1ns/1ps

module addressDecoder (
    input  logic [15:0] cpuAddr,
    input  logic [7:0] ramData,
    input  logic [7:0] cartData,
    input  logic [7:0] biosData,
    output logic ramSel,
    output logic cartSelLo,
    output logic cartSelHi,
    output logic biosSel,
    output logic [7:0] readData
);
    import panelPkg::*;

    // region compare
    always_comb begin
        ramSel = (cpuAddr <= RAM_END);
        cartSelLo = (cpuAddr > RAM_END) && (cpuAddr <= CART_LO_END);
        cartSelHi = (cpuAddr > CART_LO_END) && (cpuAddr <= CART_HI_END);
        // gap between cartridge and bios selects nothing
        biosSel = (cpuAddr >= BIOS_BASE);
    end

    // both cart banks share one data port
    always_comb begin
        if (ramSel)
            readData = ramData;
        else if (cartSelLo || cartSelHi)
            readData = cartData;
        else if (biosSel)
            readData = biosData;
        else
            readData = OPEN_BUS;
    end

    // bounds in the package must not overlap
    selOneHot: assert final ($onehot0({ramSel, cartSelLo, cartSelHi, biosSel}));

endmodule

// ==== src/lcdDriver.sv ====
// 4-bit character LCD interface
// power-up wait, fixed init command list, byte writes as two timed nibbles
`timescale 1ns/1ps

module lcdDriver #(
    parameter int LCD_POWERUP_CYCLES = 1000000,
    parameter int LCD_PULSE_CYCLES = 25,
    parameter int LCD_WAIT_CYCLES = 100000
) (
    input  logic clk,
    input  logic rstN,
    input  logic writeStart,
    input  panelPkg::lcdChar writeData,
    input  logic writeRs,
    output logic writeDone,
    output logic initDone,
    output logic lcdRs,
    output logic lcdRw,
    output logic lcdE,
    output logic [3:0] lcdData
);
    import panelPkg::*;

    // one counter serves every delay
    localparam int MAX_DELAY =
        (LCD_POWERUP_CYCLES > LCD_WAIT_CYCLES) ?
        ((LCD_POWERUP_CYCLES > LCD_PULSE_CYCLES) ? LCD_POWERUP_CYCLES : LCD_PULSE_CYCLES) :
        ((LCD_WAIT_CYCLES > LCD_PULSE_CYCLES) ? LCD_WAIT_CYCLES : LCD_PULSE_CYCLES);
    localparam int CNT_W = $clog2(MAX_DELAY + 1);

    typedef enum logic [2:0] {
        stPowerUp,
        stHiE,
        stHiGap,
        stLoE,
        stLoGap,
        stSettle,
        stIdle
    } lcdState;

    lcdState state;
    logic [CNT_W-1:0] delay;
    logic [1:0] initIdx;
    lcdChar byteReg;
    logic rsReg;

    // init list in send order
    function automatic lcdChar initCommand(input logic [1:0] idx);
        case (idx)
            2'd0: return LCD_FUNCTION_4BIT;
            2'd1: return LCD_DISPLAY_ON;
            2'd2: return LCD_ENTRY;
            default: return LCD_CLEAR;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        writeDone <= 1'b0;
        if (!rstN) begin
            state <= stPowerUp;
            delay <= CNT_W'(LCD_POWERUP_CYCLES - 1);
            initIdx <= '0;
            initDone <= 1'b0;
        end else begin
            case (state)
                stPowerUp: begin
                    if (delay == '0) begin
                        byteReg <= initCommand(2'd0);
                        rsReg <= 1'b0;
                        delay <= CNT_W'(LCD_PULSE_CYCLES - 1);
                        state <= stHiE;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                // E pulse and gap per nibble, all the same width
                stHiE, stHiGap, stLoE: begin
                    if (delay == '0) begin
                        delay <= CNT_W'(LCD_PULSE_CYCLES - 1);
                        if (state == stHiE)
                            state <= stHiGap;
                        else if (state == stHiGap)
                            state <= stLoE;
                        else
                            state <= stLoGap;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                stLoGap: begin
                    if (delay == '0) begin
                        delay <= CNT_W'(LCD_WAIT_CYCLES - 1);
                        state <= stSettle;
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end
                stSettle: begin
                    if (delay != '0) begin
                        delay <= delay - 1'b1;
                    end else if (initDone) begin
                        writeDone <= 1'b1;
                        state <= stIdle;
                    end else if (initIdx == 2'd3) begin
                        // clear was the last init command
                        initDone <= 1'b1;
                        state <= stIdle;
                    end else begin
                        initIdx <= initIdx + 1'b1;
                        byteReg <= initCommand(initIdx + 1'b1);
                        delay <= CNT_W'(LCD_PULSE_CYCLES - 1);
                        state <= stHiE;
                    end
                end
                default: begin
                    if (writeStart) begin
                        byteReg <= writeData;
                        rsReg <= writeRs;
                        delay <= CNT_W'(LCD_PULSE_CYCLES - 1);
                        state <= stHiE;
                    end
                end
            endcase
        end
    end

    // high nibble first
    assign lcdE = (state == stHiE) || (state == stLoE);
    assign lcdData = (state == stHiE || state == stHiGap) ? byteReg[7:4] : byteReg[3:0];
    assign lcdRs = rsReg;
    // write only, busy flag never polled
    assign lcdRw = 1'b0;

    // sequencer waits for writeDone and for init
    startWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        writeStart |-> (state == stIdle) && initDone);

    // panel latches data on the falling edge of E
    dataStableInPulse: assert property (@(posedge clk) disable iff (!rstN)
        lcdE && $past(lcdE) |-> $stable(lcdData));

endmodule

// ==== src/panelSequencer.sv ====
// LCD frame sequencer for the debug panel
// snapshots CPU state on phi1, formats hex text, feeds the LCD driver
// a clear button edge sends a lone clear command
`timescale 1ns/1ps

module panelSequencer (
    input  logic clk,
    input  logic rstN,
    input  logic phi1,
    input  logic [7:0] regA,
    input  logic [7:0] regX,
    input  logic [7:0] regY,
    input  logic [7:0] opcode,
    input  logic [panelPkg::SWITCH_COUNT-1:0] lineLevel,
    input  logic initDone,
    input  logic writeDone,
    output logic writeStart,
    output panelPkg::lcdChar writeData,
    output logic writeRs,
    output logic busy
);
    import panelPkg::*;

    // byte 0 clear, 1..16 line 1, 17 line-2 address, 18..33 line 2
    localparam int LINE2_IDX = 17;
    localparam int FRAME_LAST = 33;

    logic phi1Q;
    logic clearQ;
    logic phi1Rise;
    logic clearRise;
    logic startFrame;
    logic clearOnly;
    logic [5:0] charIdx;
    logic [7:0] snapA;
    logic [7:0] snapX;
    logic [7:0] snapY;
    logic [7:0] snapOp;
    logic [SWITCH_COUNT-1:0] snapLevel;
    logic [16*8-1:0] line1Text;
    logic [16*8-1:0] line2Text;

    function automatic lcdChar hexDigit(input logic [3:0] nib);
        // upper-case A..F
        return (nib < 4'd10) ? ("0" + 8'(nib)) : ("A" + 8'(nib) - 8'd10);
    endfunction

    function automatic lcdChar bitChar(input logic level);
        return level ? "1" : "0";
    endfunction

    assign phi1Rise = phi1 && !phi1Q;
    assign clearRise = lineLevel[SW_CLEAR] && !clearQ;
    // edges while busy or before init are dropped
    assign startFrame = !busy && initDone && phi1Rise;

    always_ff @(posedge clk) begin
        writeStart <= 1'b0;
        if (!rstN) begin
            // a level already high at reset is not an edge
            phi1Q <= 1'b1;
            clearQ <= 1'b1;
            busy <= 1'b0;
            clearOnly <= 1'b0;
            charIdx <= '0;
        end else begin
            phi1Q <= phi1;
            clearQ <= lineLevel[SW_CLEAR];
            if (!busy) begin
                if (initDone && (phi1Rise || clearRise)) begin
                    // a frame begins with clear anyway
                    busy <= 1'b1;
                    clearOnly <= !phi1Rise;
                    charIdx <= '0;
                    writeStart <= 1'b1;
                end
            end else if (writeDone) begin
                if (clearOnly || charIdx == 6'(FRAME_LAST)) begin
                    busy <= 1'b0;
                end else begin
                    charIdx <= charIdx + 1'b1;
                    writeStart <= 1'b1;
                end
            end
        end
    end

    // snapshot held for the whole frame
    always_ff @(posedge clk) begin
        if (startFrame) begin
            snapA <= regA;
            snapX <= regX;
            snapY <= regY;
            snapOp <= opcode;
            snapLevel <= lineLevel;
        end
    end

    // "A=hh X=hh Y=hh  "
    assign line1Text = {"A=", hexDigit(snapA[7:4]), hexDigit(snapA[3:0]),
                        " X=", hexDigit(snapX[7:4]), hexDigit(snapX[3:0]),
                        " Y=", hexDigit(snapY[7:4]), hexDigit(snapY[3:0]), "  "};
    // "OP=hh H I N R   " with line levels as digits
    assign line2Text = {"OP=", hexDigit(snapOp[7:4]), hexDigit(snapOp[3:0]),
                        " ", bitChar(snapLevel[SW_HALT]), " ", bitChar(snapLevel[SW_IRQ]),
                        " ", bitChar(snapLevel[SW_NMI]), " ", bitChar(snapLevel[SW_RES]),
                        "   "};

    // first character sits in the top byte of each line
    always_comb begin
        if (charIdx == '0)
            writeData = LCD_CLEAR;
        else if (charIdx == 6'(LINE2_IDX))
            writeData = LCD_LINE2;
        else if (charIdx < 6'(LINE2_IDX))
            writeData = line1Text[(16 - charIdx) * 8 +: 8];
        else
            writeData = line2Text[(FRAME_LAST - charIdx) * 8 +: 8];
    end

    // commands go out with RS low
    assign writeRs = (charIdx != '0) && (charIdx != 6'(LINE2_IDX));

endmodule

// ==== src/cpuDebugPanel.sv ====
// top level of the CPU debug panel
// switch sampler, debouncer array, address decoder, LCD sequencer and driver
`timescale 1ns/1ps

module cpuDebugPanel #(
    parameter int SAMPLE_DIV = 50000,
    parameter int DEBOUNCE_SAMPLES = 16,
    parameter int LCD_POWERUP_CYCLES = 1000000,
    parameter int LCD_PULSE_CYCLES = 25,
    parameter int LCD_WAIT_CYCLES = 100000
) (
    input  logic clk,
    input  logic rstN,
    input  logic [panelPkg::SWITCH_COUNT-1:0] rawSwitch,
    input  logic phi1,
    input  logic [7:0] regA,
    input  logic [7:0] regX,
    input  logic [7:0] regY,
    input  logic [7:0] opcode,
    input  logic [15:0] cpuAddr,
    input  logic [7:0] ramData,
    input  logic [7:0] cartData,
    input  logic [7:0] biosData,
    output logic halt,
    output logic irqN,
    output logic nmiN,
    output logic resN,
    output logic ramSel,
    output logic cartSelLo,
    output logic cartSelHi,
    output logic biosSel,
    output logic [7:0] readData,
    output logic lcdRs,
    output logic lcdRw,
    output logic lcdE,
    output logic [3:0] lcdData,
    output logic panelReady,
    output logic panelBusy
);
    import panelPkg::*;

    logic [SWITCH_COUNT-1:0] syncSwitch;
    logic [SWITCH_COUNT-1:0] stable;
    logic sampleTick;
    logic writeStart;
    logic writeDone;
    logic writeRs;
    lcdChar writeData;

    switchSampler #(.SAMPLE_DIV(SAMPLE_DIV)) i_sampler (
        .clk, .rstN, .rawSwitch, .syncSwitch, .sampleTick
    );

    // one debouncer per switch, all on the shared tick
    for (genvar i = 0; i < SWITCH_COUNT; i++) begin : gDebounce
        debounce #(.DEBOUNCE_SAMPLES(DEBOUNCE_SAMPLES)) i_debounce (
            .clk, .rstN, .sampleTick,
            .rawLevel(syncSwitch[i]),
            .resetLevel(SWITCH_RESET_LEVEL[i]),
            .stableLevel(stable[i])
        );
    end

    // CPU control lines
    assign halt = stable[SW_HALT];
    assign irqN = stable[SW_IRQ];
    assign nmiN = stable[SW_NMI];
    assign resN = stable[SW_RES];

    addressDecoder i_decoder (
        .cpuAddr, .ramData, .cartData, .biosData,
        .ramSel, .cartSelLo, .cartSelHi, .biosSel, .readData
    );

    panelSequencer i_sequencer (
        .clk, .rstN, .phi1, .regA, .regX, .regY, .opcode,
        .lineLevel(stable), .initDone(panelReady), .writeDone,
        .writeStart, .writeData, .writeRs, .busy(panelBusy)
    );

    lcdDriver #(
        .LCD_POWERUP_CYCLES(LCD_POWERUP_CYCLES),
        .LCD_PULSE_CYCLES(LCD_PULSE_CYCLES),
        .LCD_WAIT_CYCLES(LCD_WAIT_CYCLES)
    ) i_lcd (
        .clk, .rstN, .writeStart, .writeData, .writeRs, .writeDone,
        .initDone(panelReady), .lcdRs, .lcdRw, .lcdE, .lcdData
    );

endmodule

// ==== bench/lcdModel.sv ====
// behavioral 4-bit character LCD
// pairs nibbles on the falling edge of E, keeps a two-line screen buffer
`timescale 1ns/1ps

module lcdModel (
    input  logic rstN,
    input  logic lcdE,
    input  logic lcdRs,
    input  logic [3:0] lcdData,
    output logic byteStrobe,
    output logic [16*8-1:0] line1,
    output logic [16*8-1:0] line2
);

    logic [7:0] screen [2][16];
    logic haveHigh;
    logic [3:0] highNibble;
    logic row;
    logic [3:0] col;

    // HD44780 subset: clear, set DDRAM address, character write
    task automatic applyByte(input logic rs, input logic [7:0] b);
        int r;
        int c;
        if (rs) begin
            screen[row][col] = b;
            col = col + 1'b1;
        end else if (b == 8'h01) begin
            for (r = 0; r < 2; r++)
                for (c = 0; c < 16; c++)
                    screen[r][c] = 8'h20;
            row = 1'b0;
            col = '0;
        end else if (b[7]) begin
            // bit 6 picks the line, 0x40 base
            row = b[6];
            col = b[3:0];
        end
    endtask

    initial begin
        byteStrobe = 1'b0;
        haveHigh = 1'b0;
        applyByte(1'b0, 8'h01);
    end

    // high nibble arrives first
    always @(negedge lcdE) begin
        if (!rstN) begin
            haveHigh = 1'b0;
        end else if (!haveHigh) begin
            highNibble = lcdData;
            haveHigh = 1'b1;
        end else begin
            haveHigh = 1'b0;
            applyByte(lcdRs, {highNibble, lcdData});
            byteStrobe = 1'b1;
            #1 byteStrobe = 1'b0;
        end
    end

    // leftmost column in the top byte
    always_comb begin
        for (int c = 0; c < 16; c++) begin
            line1[(15 - c) * 8 +: 8] = screen[0][c];
            line2[(15 - c) * 8 +: 8] = screen[1][c];
        end
    end

endmodule

// ==== bench/panelTb.sv ====
// testbench for the CPU debug panel
// reset, address decode, debounce, LCD frame and clear checks as assertions
// LFSR stimulus, cycle-count watchdog, closing report
`timescale 1ns/1ps

module panelTb;
    import panelPkg::*;

    localparam int SAMPLE_DIV = 4;
    localparam int DEBOUNCE_SAMPLES = 4;
    localparam int LCD_POWERUP_CYCLES = 50;
    localparam int LCD_PULSE_CYCLES = 2;
    localparam int LCD_WAIT_CYCLES = 4;

    localparam int GLITCH_CYCLES = 2 * SAMPLE_DIV;
    localparam int HOLD_CYCLES = 8 * SAMPLE_DIV;
    // shortest input run that may move an output and the worst latency
    localparam int MIN_RUN = (DEBOUNCE_SAMPLES - 1) * SAMPLE_DIV;
    localparam int MAX_LATENCY = 2 + (DEBOUNCE_SAMPLES + 1) * SAMPLE_DIV;
    localparam int DECODE_COUNT = 200;
    localparam int BYTE_CYCLES = 4 * LCD_PULSE_CYCLES + LCD_WAIT_CYCLES + 2;
    localparam int INIT_CYCLES = LCD_POWERUP_CYCLES + 4 * BYTE_CYCLES;
    localparam int FRAME_CYCLES = 35 * BYTE_CYCLES;
    localparam int SWITCH_CYCLES = 4 * GLITCH_CYCLES + 13 * HOLD_CYCLES;
    localparam int TIMEOUT_CYCLES =
        (8 + DECODE_COUNT + 10 + INIT_CYCLES + 3 * FRAME_CYCLES + SWITCH_CYCLES) * 3 / 2;
    // control lines idle high and clear button released
    localparam logic [SWITCH_COUNT-1:0] IDLE_SWITCH = 5'b01111;

    logic clk;
    logic rstN;
    logic [SWITCH_COUNT-1:0] rawSwitch;
    logic phi1;
    logic [7:0] regA;
    logic [7:0] regX;
    logic [7:0] regY;
    logic [7:0] opcode;
    logic [15:0] cpuAddr;
    logic [7:0] ramData;
    logic [7:0] cartData;
    logic [7:0] biosData;
    logic halt;
    logic irqN;
    logic nmiN;
    logic resN;
    logic ramSel;
    logic cartSelLo;
    logic cartSelHi;
    logic biosSel;
    logic [7:0] readData;
    logic lcdRs;
    logic lcdRw;
    logic lcdE;
    logic [3:0] lcdData;
    logic panelReady;
    logic panelBusy;

    logic byteStrobe;
    logic [16*8-1:0] line1;
    logic [16*8-1:0] line2;
    logic [16*8-1:0] expLine1;
    logic [16*8-1:0] expLine2;
    logic [3:0] ctrlLevel;
    logic [SWITCH_COUNT-1:0] lastRaw = IDLE_SWITCH;
    int runLen [SWITCH_COUNT];
    logic [31:0] lfsr = 32'hb8e1_aaeb;
    logic [15:0] edgeAddr [10] = '{16'h0000, 16'h3FFF, 16'h4000, 16'h7FFF, 16'h8000,
                                   16'hBFFF, 16'hC000, 16'hF7FF, 16'hF800, 16'hFFFF};
    string lineName [4] = '{"halt", "irqN", "nmiN", "resN"};
    int cycleCount = 0;
    int errorCount = 0;
    int bytesSeen = 0;
    int frameStartBytes = 0;
    int expBytes = 34;
    logic startAllowed = 1'b0;
    logic busyQ = 1'b0;

    cpuDebugPanel #(
        .SAMPLE_DIV(SAMPLE_DIV),
        .DEBOUNCE_SAMPLES(DEBOUNCE_SAMPLES),
        .LCD_POWERUP_CYCLES(LCD_POWERUP_CYCLES),
        .LCD_PULSE_CYCLES(LCD_PULSE_CYCLES),
        .LCD_WAIT_CYCLES(LCD_WAIT_CYCLES)
    ) i_dut (
        .clk, .rstN, .rawSwitch, .phi1, .regA, .regX, .regY, .opcode,
        .cpuAddr, .ramData, .cartData, .biosData,
        .halt, .irqN, .nmiN, .resN, .ramSel, .cartSelLo, .cartSelHi, .biosSel,
        .readData, .lcdRs, .lcdRw, .lcdE, .lcdData, .panelReady, .panelBusy
    );

    lcdModel i_screen (
        .rstN, .lcdE, .lcdRs, .lcdData, .byteStrobe, .line1, .line2
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // right-shifting form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galoisStep(lfsr);
            bits[i] = lfsr[0];
        end
    endtask

    // {ramSel, cartSelLo, cartSelHi, biosSel, readData} from the memory map
    function automatic logic [11:0] expectedDecode(input logic [15:0] a,
            input logic [7:0] r, input logic [7:0] c, input logic [7:0] b);
        if (a < 16'h4000)
            return {4'b1000, r};
        if (a < 16'h8000)
            return {4'b0100, c};
        if (a < 16'hC000)
            return {4'b0010, c};
        if (a >= 16'hF800)
            return {4'b0001, b};
        return {4'b0000, 8'hFF};
    endfunction

    function automatic logic [7:0] hexChar(input logic [3:0] nib);
        return (nib > 4'd9) ? 8'h37 + 8'(nib) : 8'h30 + 8'(nib);
    endfunction

    function automatic logic [7:0] digitFor(input logic level);
        return level ? 8'h31 : 8'h30;
    endfunction

    function automatic logic [16*8-1:0] line1Text(input logic [7:0] a,
            input logic [7:0] x, input logic [7:0] y);
        return {"A=", hexChar(a[7:4]), hexChar(a[3:0]), " X=", hexChar(x[7:4]),
                hexChar(x[3:0]), " Y=", hexChar(y[7:4]), hexChar(y[3:0]), "  "};
    endfunction

    function automatic logic [16*8-1:0] line2Text(input logic [7:0] op,
            input logic [SWITCH_COUNT-1:0] lev);
        return {"OP=", hexChar(op[7:4]), hexChar(op[3:0]), " ", digitFor(lev[SW_HALT]),
                " ", digitFor(lev[SW_IRQ]), " ", digitFor(lev[SW_NMI]), " ",
                digitFor(lev[SW_RES]), "   "};
    endfunction

    task automatic reportValue(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        errorCount++;
        $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic reportText(input string name, input logic [16*8-1:0] got,
            input logic [16*8-1:0] exp);
        errorCount++;
        $display("ERROR %0t %s got \"%s\" expected \"%s\"", $time, name, got, exp);
    endtask

    task automatic applyAddress(input logic [15:0] a);
        logic [31:0] r;
        @(negedge clk);
        cpuAddr = a;
        takeBits(8, r);
        ramData = r[7:0];
        takeBits(8, r);
        cartData = r[7:0];
        takeBits(8, r);
        biosData = r[7:0];
    endtask

    task automatic holdSwitch(input int idx, input logic level, input int cycles);
        @(negedge clk);
        rawSwitch[idx] = level;
        repeat (cycles - 1) @(negedge clk);
    endtask

    // random registers and one phi1 edge plus optional extra edges while busy
    task automatic showFrame(input int extraEdges);
        logic [31:0] r;
        int k;
        @(negedge clk);
        takeBits(8, r);
        regA = r[7:0];
        takeBits(8, r);
        regX = r[7:0];
        takeBits(8, r);
        regY = r[7:0];
        takeBits(8, r);
        opcode = r[7:0];
        // switches were held far past the debounce latency
        expLine1 = line1Text(regA, regX, regY);
        expLine2 = line2Text(opcode, rawSwitch);
        expBytes = 34;
        startAllowed = 1'b1;
        @(negedge clk);
        phi1 = 1'b1;
        while (!panelBusy) @(negedge clk);
        for (k = 0; k < extraEdges; k++) begin
            repeat (BYTE_CYCLES) @(negedge clk);
            phi1 = 1'b0;
            repeat (BYTE_CYCLES) @(negedge clk);
            phi1 = 1'b1;
        end
        while (panelBusy) @(negedge clk);
        startAllowed = 1'b0;
        phi1 = 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk);
    endtask

    assign ctrlLevel = {resN, nmiN, irqN, halt};

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        busyQ <= panelBusy;
        if (panelBusy && !busyQ)
            frameStartBytes <= bytesSeen;
        // run length of each raw switch level
        lastRaw <= rawSwitch;
        for (int i = 0; i < SWITCH_COUNT; i++)
            runLen[i] <= (rawSwitch[i] != lastRaw[i]) ? 1 : runLen[i] + 1;
    end

    always @(posedge byteStrobe)
        bytesSeen <= bytesSeen + 1;

    resetState: assert property (@(posedge clk) (cycleCount > 0) && (!rstN || $past(!rstN))
        |-> !lcdE && !panelReady && !panelBusy && halt && irqN && nmiN && resN)
        else reportValue("{lcdE,panelReady,panelBusy,halt,irqN,nmiN,resN}",
            32'($sampled({lcdE, panelReady, panelBusy, halt, irqN, nmiN, resN})), 32'h0F);

    // the panel only ever writes to the LCD
    writeOnly: assert property (@(posedge clk) !lcdRw)
        else reportValue("lcdRw", 32'($sampled(lcdRw)), 32'h0);

    decodeMap: assert property (@(posedge clk)
        {ramSel, cartSelLo, cartSelHi, biosSel, readData}
            == expectedDecode(cpuAddr, ramData, cartData, biosData))
        else reportValue("{ramSel,cartSelLo,cartSelHi,biosSel,readData}",
            32'({ramSel, cartSelLo, cartSelHi, biosSel, readData}),
            32'(expectedDecode(cpuAddr, ramData, cartData, biosData)));

    for (genvar i = 0; i < 4; i++) begin : gLineCheck
        // output may only move to a level that was held long enough
        filterGlitch: assert property (@(posedge clk) disable iff (!rstN)
            $changed(ctrlLevel[i]) |-> ctrlLevel[i] == lastRaw[i] && runLen[i] >= MIN_RUN)
            else begin
                errorCount++;
                $display("%0t: %s changed although its switch had not held the new level",
                    $time, lineName[i]);
            end
        followLevel: assert property (@(posedge clk) disable iff (!rstN)
            runLen[i] >= MAX_LATENCY |-> ctrlLevel[i] == lastRaw[i])
            else reportValue(lineName[i], 32'($sampled(ctrlLevel[i])), 32'($sampled(lastRaw[i])));
    end

    frameLine1: assert property (@(posedge clk) disable iff (!rstN)
        $fell(panelBusy) |-> line1 == expLine1)
        else reportText("lcd line1", $sampled(line1), expLine1);

    frameLine2: assert property (@(posedge clk) disable iff (!rstN)
        $fell(panelBusy) |-> line2 == expLine2)
        else reportText("lcd line2", $sampled(line2), expLine2);

    frameLength: assert property (@(posedge clk) disable iff (!rstN)
        $fell(panelBusy) |-> bytesSeen - frameStartBytes == expBytes)
        else reportValue("lcd byte count", $sampled(bytesSeen - frameStartBytes), expBytes);

    // dropped edges must not start a frame later on
    requestedStart: assert property (@(posedge clk) disable iff (!rstN)
        $rose(panelBusy) |-> startAllowed)
        else begin
            errorCount++;
            $display("%0t: panel went busy without a phi1 edge or clear press", $time);
        end

    initial begin
        while (cycleCount < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the panel never finished its work", cycleCount);
        $display("errors: %0d", errorCount);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int i;
        rstN = 1'b0;
        rawSwitch = IDLE_SWITCH;
        phi1 = 1'b0;
        regA = '0;
        regX = '0;
        regY = '0;
        opcode = '0;
        cpuAddr = '0;
        ramData = '0;
        cartData = '0;
        biosData = '0;
        expLine1 = {16{8'h20}};
        expLine2 = {16{8'h20}};
        repeat (8) @(negedge clk);
        rstN = 1'b1;

        // region edges first and random addresses after
        for (i = 0; i < 10; i++)
            applyAddress(edgeAddr[i]);
        for (i = 0; i < DECODE_COUNT; i++) begin
            takeBits(16, r);
            applyAddress(r[15:0]);
        end

        // glitches must vanish and held levels must come through
        holdSwitch(SW_IRQ, 1'b0, GLITCH_CYCLES);
        holdSwitch(SW_IRQ, 1'b1, HOLD_CYCLES);
        holdSwitch(SW_NMI, 1'b0, GLITCH_CYCLES);
        holdSwitch(SW_NMI, 1'b1, HOLD_CYCLES);
        holdSwitch(SW_IRQ, 1'b0, HOLD_CYCLES);
        holdSwitch(SW_NMI, 1'b0, HOLD_CYCLES);
        holdSwitch(SW_IRQ, 1'b1, GLITCH_CYCLES);
        holdSwitch(SW_IRQ, 1'b0, HOLD_CYCLES);
        holdSwitch(SW_NMI, 1'b1, GLITCH_CYCLES);
        holdSwitch(SW_NMI, 1'b0, HOLD_CYCLES);
        holdSwitch(SW_NMI, 1'b1, HOLD_CYCLES);

        while (!panelReady) @(negedge clk);
        showFrame(0);
        holdSwitch(SW_HALT, 1'b0, HOLD_CYCLES);
        showFrame(3);

        // a clear press sends only the clear command
        @(negedge clk);
        expLine1 = {16{8'h20}};
        expLine2 = {16{8'h20}};
        expBytes = 1;
        startAllowed = 1'b1;
        rawSwitch[SW_CLEAR] = 1'b1;
        while (!panelBusy) @(negedge clk);
        while (panelBusy) @(negedge clk);
        startAllowed = 1'b0;
        holdSwitch(SW_CLEAR, 1'b1, HOLD_CYCLES);
        holdSwitch(SW_CLEAR, 1'b0, 2 * HOLD_CYCLES);

        $display("errors: %0d", errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
src/panelPkg.sv
src/switchSampler.sv
src/debounce.sv
src/addressDecoder.sv
src/lcdDriver.sv
src/panelSequencer.sv
src/cpuDebugPanel.sv
bench/lcdModel.sv
bench/panelTb.sv

// ==== Bender.yml ====
package:
  name: cpu_debug_panel

sources:
  - src/panelPkg.sv
  - src/switchSampler.sv
  - src/debounce.sv
  - src/addressDecoder.sv
  - src/lcdDriver.sv
  - src/panelSequencer.sv
  - src/cpuDebugPanel.sv
  - target: test
    files:
      - bench/lcdModel.sv
      - bench/panelTb.sv
